//--- hw/tl_pkg.sv
// Shared word format, FIFO sizing and controller state encoding
package tl_pkg;

	// Word format
	localparam int WORD_W    = 6;
	localparam int CLASS_BIT = 5;	// Top bit picks the virtual channel

	// FIFO sizing
	localparam int FIFO_DEPTH = 4;
	localparam int FILL_W     = 3;	// Wide enough to hold FIFO_DEPTH itself

	// Input, two channels and output
	localparam int NUM_FIFOS = 4;

	// Bit positions of each FIFO in the controller's status vectors
	localparam int IDX_IN  = 0;
	localparam int IDX_VC0 = 1;
	localparam int IDX_VC1 = 2;
	localparam int IDX_OUT = 3;

	// Flow-control controller states
	typedef enum logic [2:0] {
		FC_RESET  = 3'd0,
		FC_INIT   = 3'd1,
		FC_IDLE   = 3'd2,
		FC_ACTIVE = 3'd3,
		FC_ERROR  = 3'd4
	} fc_state_t;

endpackage

//--- hw/fifo.sv
`timescale 1ns/1ps

module fifo #(
	parameter int BW    = tl_pkg::WORD_W,
	parameter int DEPTH = tl_pkg::FIFO_DEPTH
) (
	input  logic                      clk,
	input  logic                      reset_L,
	input  logic                      i_wr,
	input  logic [BW-1:0]             i_data,
	input  logic                      i_rd,
	input  logic [tl_pkg::FILL_W-1:0] i_umbral_bajo,
	input  logic [tl_pkg::FILL_W-1:0] i_umbral_alto,
	output logic [BW-1:0]             o_data,
	output logic                      o_error,
	output logic                      o_full,
	output logic                      o_empty,
	output logic                      o_almost_full,
	output logic                      o_almost_empty
);
	import tl_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam logic [PTR_W-1:0]  PTR_LAST = PTR_W'(DEPTH - 1);
	localparam logic [FILL_W-1:0] FILL_MAX = FILL_W'(DEPTH);

	logic [BW-1:0]     mem [DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [FILL_W-1:0] fill;
	logic              overrun;
	logic              underrun;
	logic              wr_ok;
	logic              rd_ok;

	// A write into a full FIFO still goes through when a read frees a slot
	assign wr_ok = i_wr && (!o_full || i_rd);
	assign rd_ok = i_rd && !o_empty;

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem[wr_ptr] <= i_data;
		end
	end

	// Head word shows up only during a read
	always_comb begin
		o_data = '0;
		if (rd_ok) begin
			o_data = mem[rd_ptr];
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_L) begin
			wr_ptr  <= '0;
			overrun <= 1'b0;
		end else if (i_wr) begin
			if (wr_ok) begin
				wr_ptr  <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
				overrun <= 1'b0;
			end else begin
				overrun <= 1'b1;	// Word dropped
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_L) begin
			rd_ptr   <= '0;
			underrun <= 1'b0;
		end else if (i_rd) begin
			if (rd_ok) begin
				rd_ptr   <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
				underrun <= 1'b0;
			end else begin
				underrun <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_L) begin
			fill <= '0;
		end else begin
			case ({wr_ok, rd_ok})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;	// Idle, or read and write cancel out
			endcase
		end
	end

	assign o_error        = overrun | underrun;
	assign o_full         = (fill == FILL_MAX);
	assign o_empty        = (fill == '0);
	assign o_almost_full  = (fill == i_umbral_alto);
	assign o_almost_empty = (fill == i_umbral_bajo);

endmodule

//--- hw/vc_demux.sv
`timescale 1ns/1ps

module vc_demux (
	input  logic                      i_in_empty,
	input  logic [tl_pkg::WORD_W-1:0] i_in_data,
	input  logic                      i_vc0_full,
	input  logic                      i_vc1_full,
	output logic                      o_in_rd,
	output logic                      o_vc0_wr,
	output logic                      o_vc1_wr,
	output logic [tl_pkg::WORD_W-1:0] o_vc_data
);
	import tl_pkg::*;

	logic class_sel;

	// The input FIFO presents its head word only while it is being read,
	// so the class bit is not known before the strobe goes out. Reading
	// only when both channels have room means the chosen one always does,
	// and the strobe never depends on the word it returns.
	assign o_in_rd = !i_in_empty && !i_vc0_full && !i_vc1_full;

	assign class_sel = i_in_data[CLASS_BIT];

	// Route the word at the same edge it leaves the input FIFO
	assign o_vc0_wr  = o_in_rd && !class_sel;
	assign o_vc1_wr  = o_in_rd && class_sel;
	assign o_vc_data = i_in_data;

endmodule

//--- hw/vc_arbiter.sv
`timescale 1ns/1ps

module vc_arbiter (
	input  logic                      clk,
	input  logic                      reset_L,
	input  logic                      i_vc0_empty,
	input  logic                      i_vc1_empty,
	input  logic [tl_pkg::WORD_W-1:0] i_vc0_data,
	input  logic [tl_pkg::WORD_W-1:0] i_vc1_data,
	input  logic                      i_out_full,
	input  logic                      i_out_almost_full,
	output logic                      o_vc0_rd,
	output logic                      o_vc1_rd,
	output logic                      o_out_wr,
	output logic [tl_pkg::WORD_W-1:0] o_out_data
);

	logic prio;	// Channel that wins a tie
	logic stall;
	logic grant0;
	logic grant1;

	// Stop at the almost-full mark so the output keeps some slack
	assign stall = i_out_full | i_out_almost_full;

	always_comb begin
		grant0 = 1'b0;
		grant1 = 1'b0;
		if (!stall) begin
			if (prio) begin
				grant1 = !i_vc1_empty;
				grant0 = i_vc1_empty && !i_vc0_empty;	// Fall back to channel 0
			end else begin
				grant0 = !i_vc0_empty;
				grant1 = i_vc0_empty && !i_vc1_empty;
			end
		end
	end

	assign o_vc0_rd = grant0;
	assign o_vc1_rd = grant1;
	assign o_out_wr = grant0 | grant1;

	// Channel FIFO data is zero unless read, the mux just picks the live one
	assign o_out_data = grant1 ? i_vc1_data : i_vc0_data;

	// Priority flips after each word moved
	always_ff @(posedge clk) begin
		if (!reset_L) begin
			prio <= 1'b0;
		end else if (o_out_wr) begin
			prio <= ~prio;
		end
	end

endmodule

//--- hw/flow_ctrl_fsm.sv
`timescale 1ns/1ps

module flow_ctrl_fsm (
	input  logic                         clk,
	input  logic                         reset_L,
	input  logic                         i_init,
	input  logic [tl_pkg::FILL_W-1:0]    i_umbral_bajo,
	input  logic [tl_pkg::FILL_W-1:0]    i_umbral_alto,
	input  logic [tl_pkg::NUM_FIFOS-1:0] i_errors,
	input  logic [tl_pkg::NUM_FIFOS-1:0] i_empties,
	output logic [tl_pkg::FILL_W-1:0]    o_umbral_bajo,
	output logic [tl_pkg::FILL_W-1:0]    o_umbral_alto,
	output tl_pkg::fc_state_t            o_state,
	output logic                         o_idle
);
	import tl_pkg::*;

	fc_state_t state;
	fc_state_t state_nxt;
	logic      any_error;
	logic      all_empty;

	assign any_error = |i_errors;
	assign all_empty = &i_empties;

	always_comb begin
		state_nxt = state;
		case (state)
			FC_RESET: begin
				state_nxt = FC_INIT;
			end
			FC_INIT: begin
				if (any_error) begin
					state_nxt = FC_ERROR;
				end else if (!i_init) begin
					state_nxt = FC_IDLE;
				end
			end
			FC_IDLE, FC_ACTIVE: begin
				if (any_error) begin
					state_nxt = FC_ERROR;
				end else if (all_empty) begin
					state_nxt = FC_IDLE;
				end else begin
					state_nxt = FC_ACTIVE;
				end
			end
			FC_ERROR: begin
				state_nxt = FC_ERROR;	// Only reset gets out
			end
			default: begin
				state_nxt = FC_RESET;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_L) begin
			state <= FC_RESET;
		end else begin
			state <= state_nxt;
		end
	end

	// Thresholds reload every cycle spent in init
	always_ff @(posedge clk) begin
		if (!reset_L) begin
			o_umbral_bajo <= '0;
			o_umbral_alto <= '0;
		end else if (state == FC_INIT) begin
			o_umbral_bajo <= i_umbral_bajo;
			o_umbral_alto <= i_umbral_alto;
		end
	end

	assign o_state = state;
	assign o_idle  = (state == FC_IDLE);

endmodule

//--- hw/tl_switch.sv
`timescale 1ns/1ps

module tl_switch (
	input  logic                      clk,
	input  logic                      reset_L,
	input  logic                      i_init,
	input  logic [tl_pkg::FILL_W-1:0] i_umbral_bajo,
	input  logic [tl_pkg::FILL_W-1:0] i_umbral_alto,
	input  logic                      i_push,
	input  logic [tl_pkg::WORD_W-1:0] i_data,
	input  logic                      i_pop,
	output logic                      o_in_full,
	output logic                      o_out_empty,
	output logic [tl_pkg::WORD_W-1:0] o_data,
	output tl_pkg::fc_state_t         o_state,
	output logic                      o_idle
);
	import tl_pkg::*;

	// Latched thresholds shared by every FIFO
	logic [FILL_W-1:0] umbral_bajo;
	logic [FILL_W-1:0] umbral_alto;

	logic              in_rd;
	logic [WORD_W-1:0] in_data;
	logic              in_empty;

	logic              vc0_wr;
	logic              vc1_wr;
	logic [WORD_W-1:0] vc_wdata;
	logic              vc0_rd;
	logic              vc1_rd;
	logic [WORD_W-1:0] vc0_rdata;
	logic [WORD_W-1:0] vc1_rdata;
	logic              vc0_full;
	logic              vc1_full;
	logic              vc0_empty;
	logic              vc1_empty;

	logic              out_wr;
	logic [WORD_W-1:0] out_wdata;
	logic              out_full;
	logic              out_almost_full;

	logic [NUM_FIFOS-1:0] errors;
	logic [NUM_FIFOS-1:0] empties;

	fifo u_in_fifo (
		.clk(clk), .reset_L(reset_L),
		.i_wr(i_push), .i_data(i_data), .i_rd(in_rd),
		.i_umbral_bajo(umbral_bajo), .i_umbral_alto(umbral_alto),
		.o_data(in_data), .o_error(errors[IDX_IN]),
		.o_full(o_in_full), .o_empty(in_empty),
		.o_almost_full(), .o_almost_empty()
	);

	vc_demux u_vc_demux (
		.i_in_empty(in_empty), .i_in_data(in_data),
		.i_vc0_full(vc0_full), .i_vc1_full(vc1_full),
		.o_in_rd(in_rd),
		.o_vc0_wr(vc0_wr), .o_vc1_wr(vc1_wr), .o_vc_data(vc_wdata)
	);

	fifo u_vc0_fifo (
		.clk(clk), .reset_L(reset_L),
		.i_wr(vc0_wr), .i_data(vc_wdata), .i_rd(vc0_rd),
		.i_umbral_bajo(umbral_bajo), .i_umbral_alto(umbral_alto),
		.o_data(vc0_rdata), .o_error(errors[IDX_VC0]),
		.o_full(vc0_full), .o_empty(vc0_empty),
		.o_almost_full(), .o_almost_empty()
	);

	fifo u_vc1_fifo (
		.clk(clk), .reset_L(reset_L),
		.i_wr(vc1_wr), .i_data(vc_wdata), .i_rd(vc1_rd),
		.i_umbral_bajo(umbral_bajo), .i_umbral_alto(umbral_alto),
		.o_data(vc1_rdata), .o_error(errors[IDX_VC1]),
		.o_full(vc1_full), .o_empty(vc1_empty),
		.o_almost_full(), .o_almost_empty()
	);

	vc_arbiter u_vc_arbiter (
		.clk(clk), .reset_L(reset_L),
		.i_vc0_empty(vc0_empty), .i_vc1_empty(vc1_empty),
		.i_vc0_data(vc0_rdata), .i_vc1_data(vc1_rdata),
		.i_out_full(out_full), .i_out_almost_full(out_almost_full),
		.o_vc0_rd(vc0_rd), .o_vc1_rd(vc1_rd),
		.o_out_wr(out_wr), .o_out_data(out_wdata)
	);

	fifo u_out_fifo (
		.clk(clk), .reset_L(reset_L),
		.i_wr(out_wr), .i_data(out_wdata), .i_rd(i_pop),
		.i_umbral_bajo(umbral_bajo), .i_umbral_alto(umbral_alto),
		.o_data(o_data), .o_error(errors[IDX_OUT]),
		.o_full(out_full), .o_empty(o_out_empty),
		.o_almost_full(out_almost_full), .o_almost_empty()
	);

	assign empties = {o_out_empty, vc1_empty, vc0_empty, in_empty};

	flow_ctrl_fsm u_flow_ctrl_fsm (
		.clk(clk), .reset_L(reset_L), .i_init(i_init),
		.i_umbral_bajo(i_umbral_bajo), .i_umbral_alto(i_umbral_alto),
		.i_errors(errors), .i_empties(empties),
		.o_umbral_bajo(umbral_bajo), .o_umbral_alto(umbral_alto),
		.o_state(o_state), .o_idle(o_idle)
	);

endmodule

//--- tests/tl_switch_properties.sv
`timescale 1ns/1ps

module tl_switch_properties (
	input logic                      clk,
	input logic                      reset_L,
	input logic                      i_pop,
	input logic                      o_out_empty,
	input logic [tl_pkg::WORD_W-1:0] o_data,
	input tl_pkg::fc_state_t         o_state,
	input logic                      o_idle
);
	import tl_pkg::*;

	int fail_count = 0;	// Read by the testbench at the end of the run

	// Output bus stays quiet unless a word is popped
	data_quiet: assert property (@(posedge clk) !i_pop |-> (o_data == '0))
		else begin
			fail_count++;
			$error("o_data is 0x%0h while i_pop is low", o_data);
		end

	// Only a falling reset_L may take the controller out of its error state
	error_sticky: assert property (@(posedge clk)
		(o_state == FC_ERROR && reset_L) |=> (o_state == FC_ERROR))
		else begin
			fail_count++;
			$error("o_state left FC_ERROR without a reset");
		end

	idle_empty: assert property (@(posedge clk) o_idle |-> o_out_empty)
		else begin
			fail_count++;
			$error("o_idle is high while the output FIFO holds words");
		end

endmodule

//--- tests/tl_switch_tb.sv
`timescale 1ns/1ps

module tl_switch_tb;
	import tl_pkg::*;

	localparam int GOLDEN_LEN = 64;
	localparam int WAIT_LIMIT = 200;	// Cycles any single wait may take

	logic              clk;
	logic              reset_L;
	logic              i_init;
	logic [FILL_W-1:0] i_umbral_bajo;
	logic [FILL_W-1:0] i_umbral_alto;
	logic              i_push;
	logic [WORD_W-1:0] i_data;
	logic              i_pop;
	logic              o_in_full;
	logic              o_out_empty;
	logic [WORD_W-1:0] o_data;
	fc_state_t         o_state;
	logic              o_idle;

	logic [11:0]       golden [0:GOLDEN_LEN-1];
	logic [WORD_W-1:0] words[$];
	logic [WORD_W-1:0] ovf_words[$];
	logic [WORD_W-1:0] exp_q0[$];	// Expected order for class bit 0
	logic [WORD_W-1:0] exp_q1[$];
	fc_state_t         ovf_state;
	int                mismatches;
	int                timeouts;
	int                others;
	int                assert_fails;
	int                pushed;
	int                popped;

	tl_switch u_tl_switch (.*);

	bind tl_switch tl_switch_properties u_tl_switch_properties (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	// Watchdog on the whole run
	initial begin
		repeat (8000) @(posedge clk);
		$display("Run did not finish within 8000 clock cycles");
		$display("sim failed");
		$finish;
	end

	task automatic check_word(input string name, input logic [WORD_W-1:0] got,
			input logic [WORD_W-1:0] exp);
		if (got !== exp) begin
			$display("ERROR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
			mismatches++;
		end
	endtask

	task automatic check_state(input string name, input fc_state_t got, input fc_state_t exp);
		if (got !== exp) begin
			$display("ERROR %s got 0x%0h (%s) expected 0x%0h (%s) at %0t",
				name, got, got.name(), exp, exp.name(), $time);
			mismatches++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
			mismatches++;
		end
	endtask

	task automatic wait_state(input fc_state_t exp);
		int n;
		n = 0;
		@(negedge clk);
		while (o_state != exp && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (o_state != exp) begin
			$display("Timed out waiting for the switch to reach state %s", exp.name());
			timeouts++;
		end
	endtask

	// keep_order waits for room and records the word as expected output
	task automatic push_word(input logic [WORD_W-1:0] w, input bit keep_order,
			output bit saw_full);
		int n;
		n = 0;
		@(negedge clk);
		while (keep_order && o_in_full && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		saw_full = o_in_full;
		if (keep_order && o_in_full) begin
			$display("Timed out waiting for room in the input FIFO");
			timeouts++;
		end else begin
			@(posedge clk);
			i_push <= 1'b1;
			i_data <= w;
			if (keep_order) begin
				if (w[CLASS_BIT]) begin
					exp_q1.push_back(w);
				end else begin
					exp_q0.push_back(w);
				end
				pushed++;
			end
			@(posedge clk);
			i_push <= 1'b0;
		end
	endtask

	task automatic pop_word(input bit compare, output bit ok);
		int                n;
		logic [WORD_W-1:0] got;
		logic [WORD_W-1:0] exp;
		n = 0;
		@(negedge clk);
		while (o_out_empty && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		ok = !o_out_empty;
		if (!ok) begin
			$display("Timed out waiting for a word at the output FIFO");
			timeouts++;
		end else begin
			@(posedge clk);
			i_pop <= 1'b1;
			@(negedge clk);
			got = o_data;	// Valid only while the pop is held
			@(posedge clk);
			i_pop <= 1'b0;
			if (compare) begin
				popped++;
				if (got[CLASS_BIT] && exp_q1.size() > 0) begin
					exp = exp_q1.pop_front();
					check_word("o_data", got, exp);
				end else if (!got[CLASS_BIT] && exp_q0.size() > 0) begin
					exp = exp_q0.pop_front();
					check_word("o_data", got, exp);
				end else begin
					$display("Popped word 0x%0h that was never pushed on its channel", got);
					others++;
				end
			end
		end
	endtask

	task automatic do_reset();
		@(posedge clk);
		reset_L <= 1'b0;
		i_init  <= 1'b1;
		i_push  <= 1'b0;
		i_pop   <= 1'b0;
		repeat (5) @(posedge clk);
		reset_L <= 1'b1;
		repeat (3) @(posedge clk);	// Thresholds latch in FC_INIT
		i_init <= 1'b0;
		wait_state(FC_IDLE);
	endtask

	initial begin
		bit saw_full;
		bit hit_full;
		bit ok;
		int idx;
		void'($urandom(91564));
		reset_L       = 1'b0;
		i_init        = 1'b1;
		i_umbral_bajo = '0;
		i_umbral_alto = '0;
		i_push        = 1'b0;
		i_data        = '0;
		i_pop         = 1'b0;
		mismatches    = 0;
		timeouts      = 0;
		others        = 0;
		assert_fails  = 0;
		pushed        = 0;
		popped        = 0;
		ovf_state     = FC_ERROR;

		$readmemh("tests/tl_switch_golden.txt", golden);
		idx = 0;
		while (idx < GOLDEN_LEN && !$isunknown(golden[idx]) && golden[idx] != '0) begin
			case (golden[idx][11:8])
				4'h1: begin
					i_umbral_bajo = golden[idx][6:4];
					i_umbral_alto = golden[idx][2:0];
				end
				4'h2: words.push_back(golden[idx][WORD_W-1:0]);
				4'h3: ovf_state = fc_state_t'(golden[idx][2:0]);
				4'h4: ovf_words.push_back(golden[idx][WORD_W-1:0]);
				default: begin
					$display("Unknown record 0x%0h in the golden file", golden[idx]);
					others++;
				end
			endcase
			idx++;
		end

		do_reset();
		check_state("o_state", o_state, FC_IDLE);
		check_flag("o_idle", o_idle, 1'b1);
		check_flag("o_out_empty", o_out_empty, 1'b1);

		// No pops, so the whole path backs up into the input FIFO
		idx = 0;
		@(negedge clk);
		while (idx < words.size() && !o_in_full) begin
			push_word(words[idx], 1'b1, saw_full);
			idx++;
			@(negedge clk);
		end
		check_flag("o_in_full", o_in_full, 1'b1);
		check_state("o_state", o_state, FC_ACTIVE);

		fork
			begin
				while (idx < words.size()) begin
					push_word(words[idx], 1'b1, saw_full);
					idx++;
				end
			end
			begin
				ok = 1'b1;
				while (ok && popped < words.size()) begin
					repeat ($urandom % 4) @(posedge clk);	// Idle gap between pops
					pop_word(1'b1, ok);
				end
			end
		join

		wait_state(FC_IDLE);
		check_flag("o_idle", o_idle, 1'b1);
		if (popped != pushed || exp_q0.size() != 0 || exp_q1.size() != 0) begin
			$display("Word count mismatch with %0d pushed, %0d popped, %0d still expected",
				pushed, popped, exp_q0.size() + exp_q1.size());
			others++;
		end

		// Overflow, pushing straight into a full input FIFO
		hit_full = 1'b0;
		foreach (ovf_words[i]) begin
			push_word(ovf_words[i], 1'b0, saw_full);
			hit_full |= saw_full;
		end
		if (!hit_full) begin
			$display("Overflow words never met a full input FIFO");
			others++;
		end
		wait_state(ovf_state);
		check_state("o_state", o_state, ovf_state);
		repeat (3) pop_word(1'b0, ok);
		push_word(6'h15, 1'b0, saw_full);
		@(negedge clk);
		check_state("o_state", o_state, FC_ERROR);

		// Fresh run, underrun on the empty output FIFO
		do_reset();
		check_state("o_state", o_state, FC_IDLE);
		@(posedge clk);
		i_pop <= 1'b1;
		@(posedge clk);
		i_pop <= 1'b0;
		wait_state(FC_ERROR);
		check_state("o_state", o_state, FC_ERROR);

		assert_fails = u_tl_switch.u_tl_switch_properties.fail_count;
		$display("Error counts: %0d mismatches, %0d timeouts, %0d assertion, %0d other",
			mismatches, timeouts, assert_fails, others);
		if (mismatches + timeouts + assert_fails + others == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- tests/tl_switch_golden.txt
// Switch vectors, one 3-digit hex record per entry, several per line
// Digit 1 is the kind: 1 thresholds (digit 2 low, digit 3 high), 2 push word,
// 4 overflow push word, 3 expected state after overflow; 000 ends the list

// Almost-empty 1, almost-full 3
113

// Words pushed in order, word bit 5 picks the channel
201 222 203 224
225 206 227 208
209 22A 20B 22C
22D 20E 20F 230
211 232 233 214

// Overflow burst with no pops, more than the switch can hold
410 431 412 433
414 435 416 437
418 439 41A 43B
41C 43D 41E 43F

// Controller must end in FC_ERROR
304

000

//--- filelist.f
hw/tl_pkg.sv
hw/fifo.sv
hw/vc_demux.sv
hw/vc_arbiter.sv
hw/flow_ctrl_fsm.sv
hw/tl_switch.sv
tests/tl_switch_properties.sv
tests/tl_switch_tb.sv

//--- Bender.yml
package:
  name: tl_switch

sources:
  - files:
      - hw/tl_pkg.sv
      - hw/fifo.sv
      - hw/vc_demux.sv
      - hw/vc_arbiter.sv
      - hw/flow_ctrl_fsm.sv
      - hw/tl_switch.sv
  - target: test
    files:
      - tests/tl_switch_properties.sv
      - tests/tl_switch_tb.sv
